// ==== src.f ====
+incdir+.
tofpet_pkg.sv
channel_fifo.sv
command_decode.sv
readout_execute.sv
result_sender.sv
tofpet_readout.sv
tofpet_readout_chk.sv
tb_tofpet_readout.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_tofpet_readout \
	-o sim_tofpet && \
	./obj_dir/sim_tofpet > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== tb_tofpet_readout.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module tb_tofpet_readout;

	import tofpet_pkg::*;

	localparam int CH = `TOFPET_CHANNELS;

	logic             clkin_parallel;
	logic             cpu_resetn;
	logic [CH-1:0]    hit_valid;
	hit_t             hit_data [CH];
	logic             cmd_valid;
	cmd_t             cmd;
	logic             cmd_credit;
	logic             res_valid;
	result_t          res;
	logic             res_credit;

	logic [31:0]      lfsr = 32'hb179;		// Stimulus generator state
	logic [31:0]      chan_q [CH][$];		// Model hit queues
	logic [CH-1:0]    model_ovf;			// Model sticky flags
	result_t          exp_q [$];			// Expected result words
	int               host_credits;			// Command credits held by host
	int               outstanding;			// Result words not yet retired
	int               credit_pulses;		// cmd_credit pulses seen
	int               last_credit_cycle;
	int               cycle;
	int               ret_delay;
	logic             hold;				// Host withholds res_credit

	tofpet_readout tofpet_readout_i (.*);

	// ------------------------------------------------------------------------
	// Clock, stimulus source, reference model
	// ------------------------------------------------------------------------

	initial
	begin
		clkin_parallel = 1'b0;
		forever
			#10 clkin_parallel = ~clkin_parallel;	// 20 ns period
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Expected reply of one command, applied to the model in command order
	function automatic void expect_cmd(input cmd_t c);
		result_t r;
		int      n;
		r         = '0;
		r.channel = c.channel;
		r.last    = 1'b1;
		if (c.opcode == OP_READ && c.channel < CH)
		begin
			n = (c.count < chan_q[c.channel].size()) ? c.count : chan_q[c.channel].size();
			if (n == 0)
				exp_q.push_back(r);		// Lone zero word
			for (int i = 0; i < n; i++)
			begin
				r.data = chan_q[c.channel].pop_front();
				r.last = (i == n - 1);
				exp_q.push_back(r);
			end
		end
		else if (c.opcode == OP_STATUS)
		begin
			r.kind = KIND_STATUS;
			for (int i = 0; i < CH; i++)
			begin
				r.data[2*CH+i] = (chan_q[i].size() == 0);			// Empty
				r.data[CH+i]   = (chan_q[i].size() == `TOFPET_HIT_DEPTH);	// Full
			end
			r.data[CH-1:0] = model_ovf;
			model_ovf      = '0;		// Cleared by STATUS
			exp_q.push_back(r);
		end
		else
		begin
			r.kind = KIND_ERROR;		// Bad opcode or channel
			r.data = `TOFPET_ERR_WORD;
			exp_q.push_back(r);
		end
	endfunction

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// ------------------------------------------------------------------------
	// Monitors and host result credits
	// ------------------------------------------------------------------------

	initial
	begin
		result_t e;
		cycle = 0;
		forever
		begin
			@(negedge clkin_parallel);
			cycle++;
			if (cmd_credit)
			begin
				host_credits++;
				credit_pulses++;
				last_credit_cycle = cycle;
			end
			if (res_valid)
			begin
				assert (exp_q.size() != 0)
				else fail_stop("A result word arrived while none was expected");
				e = exp_q.pop_front();
				assert (res === e)
				else fail_stop($sformatf("FAIL res expected %h actual %h", e, res));
				outstanding++;
				assert (outstanding <= `TOFPET_RES_DEPTH)
				else fail_stop("The host result buffer received more words than credits");
			end
		end
	end

	initial
	begin
		ret_delay = 0;
		forever
		begin
			@(posedge clkin_parallel);
			#2 res_credit = 1'b0;
			if (!hold && outstanding > 0)
			begin
				if (ret_delay == 0)
				begin
					res_credit  = 1'b1;		// Retire one word
					outstanding--;
					ret_delay   = take_bits(2);
				end
				else
					ret_delay--;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Host tasks
	// ------------------------------------------------------------------------

	task automatic issue_now(input logic [1:0] op, input int ch, input int cnt);
		cmd_t c;
		c            = '0;
		c.opcode     = opcode_e'(op);
		c.channel    = 3'(ch);
		c.count      = 4'(cnt);
		cmd          = c;
		cmd_valid    = 1'b1;
		host_credits--;
		expect_cmd(c);
	endtask

	task automatic send_cmd(input logic [1:0] op, input int ch, input int cnt);
		int t;
		t = 0;
		while (host_credits == 0)
		begin
			@(posedge clkin_parallel);
			t++;
			if (t > 2000)
				fail_stop("Timed out waiting for a command credit");
		end
		@(posedge clkin_parallel);
		#2 issue_now(op, ch, cnt);
		@(posedge clkin_parallel);
		#2 cmd_valid = 1'b0;
	endtask

	task automatic load_hits(input int ch, input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clkin_parallel);
			#2 hit_valid[ch] = 1'b1;
			hit_data[ch].data = take_bits(32);
			if (chan_q[ch].size() < `TOFPET_HIT_DEPTH)
				chan_q[ch].push_back(hit_data[ch].data);
			else
				model_ovf[ch] = 1'b1;		// Hit lost
		end
		@(posedge clkin_parallel);
		#2 hit_valid = '0;
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while (exp_q.size() != 0 || outstanding != 0
			|| host_credits != `TOFPET_CMD_DEPTH)
		begin
			@(posedge clkin_parallel);
			t++;
			if (t > 3000)
				fail_stop("Timed out waiting for all results and credits");
		end
	endtask

	// ------------------------------------------------------------------------
	// Test phases
	// ------------------------------------------------------------------------

	initial
	begin
		int issued;
		int rd_cnt [CH];
		cpu_resetn = 1'b0;
		hit_valid = '0;
		for (int i = 0; i < CH; i++)
			hit_data[i] = '0;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		hold = 1'b0;
		model_ovf = '0;
		host_credits = `TOFPET_CMD_DEPTH;
		outstanding = 0;
		credit_pulses = 0;
		last_credit_cycle = 0;
		repeat (16) @(posedge clkin_parallel);
		#2 cpu_resetn = 1'b1;
		repeat (4) @(posedge clkin_parallel);
		assert (credit_pulses == 0)
		else fail_stop("cmd_credit pulsed before any command was sent");
		send_cmd(OP_STATUS, 0, 0);			// All empty, nothing full
		wait_drained();
		for (int ch = 0; ch < CH; ch++)			// Random fill, no overflow
		begin
			load_hits(ch, take_bits(3) + 1);
			rd_cnt[ch] = take_bits(4);		// Drawn while no result is pending
		end
		for (int ch = 0; ch < CH; ch++)
			send_cmd(OP_READ, ch, rd_cnt[ch]);
		for (int ch = 0; ch < CH; ch++)
			send_cmd(OP_READ, ch, 15);		// Drain the rest
		wait_drained();
		load_hits(2, `TOFPET_HIT_DEPTH + 3);		// Overflow channel 2
		send_cmd(OP_STATUS, 0, 0);
		send_cmd(OP_STATUS, 0, 0);
		send_cmd(OP_READ, 2, 15);
		send_cmd(OP_READ, 4, 3);			// Empty channel
		send_cmd(2'd3, 1, 0);
		send_cmd(OP_READ, 6, 2);
		send_cmd(OP_READ, 7, 2);
		wait_drained();
		hold = 1'b1;					// Back-pressure phase
		issued = 0;
		for (int i = 0; i < 80; i++)
		begin
			@(posedge clkin_parallel);
			#2 cmd_valid = 1'b0;
			if (issued < 14 && host_credits > 0)
			begin
				issue_now(OP_STATUS, 0, 0);
				issued++;
			end
		end
		assert (host_credits == 0 && cycle - last_credit_cycle > 20)
		else fail_stop("cmd_credit kept pulsing with result credits withheld");
		hold = 1'b0;
		send_cmd(OP_STATUS, 0, 0);
		wait_drained();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tofpet_readout_chk.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module tofpet_readout_chk (
	input logic clkin_parallel,
	input logic cpu_resetn,
	input logic cmd_valid,
	input logic cmd_credit,
	input logic res_valid,
	input logic res_credit
);

	int credits;		// Mirror of the sender's result credits
	int cmds_in;		// Commands received from host
	int credits_out;	// cmd_credit pulses sent

	always_ff @(posedge clkin_parallel)
	begin
		if (!cpu_resetn)
		begin
			credits     <= `TOFPET_RES_DEPTH;
			cmds_in     <= 0;
			credits_out <= 0;
		end
		else
		begin
			credits     <= credits - int'(res_valid) + int'(res_credit);
			cmds_in     <= cmds_in + int'(cmd_valid);
			credits_out <= credits_out + int'(cmd_credit);
		end
	end

	// Result word only with a credit in hand
	a_res_credit : assert property (@(posedge clkin_parallel) disable iff (!cpu_resetn)
		res_valid |-> credits > 0)
	else $error("res_valid asserted with no result credit");

	// Never more credits back than commands in
	a_cmd_credit : assert property (@(posedge clkin_parallel) disable iff (!cpu_resetn)
		cmd_credit |-> credits_out < cmds_in)
	else $error("cmd_credit pulse without a received command");

	a_reset_quiet : assert property (@(posedge clkin_parallel)
		!cpu_resetn && $past(!cpu_resetn) |-> !res_valid)
	else $error("res_valid high during reset");

endmodule

bind tofpet_readout tofpet_readout_chk tofpet_readout_chk_i (
	.clkin_parallel (clkin_parallel),
	.cpu_resetn     (cpu_resetn),
	.cmd_valid      (cmd_valid),
	.cmd_credit     (cmd_credit),
	.res_valid      (res_valid),
	.res_credit     (res_credit)
);

`default_nettype wire

// ==== tofpet_readout.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module tofpet_readout (
	input  logic                         clkin_parallel,
	input  logic                         cpu_resetn,
	input  logic [`TOFPET_CHANNELS-1:0]  hit_valid,
	input  tofpet_pkg::hit_t             hit_data [`TOFPET_CHANNELS],
	input  logic                         cmd_valid,
	input  tofpet_pkg::cmd_t             cmd,
	output logic                         cmd_credit,
	output logic                         res_valid,
	output tofpet_pkg::result_t          res,
	input  logic                         res_credit
);

	import tofpet_pkg::*;

	logic    exec_valid;	// Decoder to executor
	cmd_t    exec_cmd;
	logic    exec_ready;
	logic    word_valid;	// Executor to sender
	result_t word;
	logic    word_ready;

	// -----------------------------------------------------------------------
	// Command path
	// -----------------------------------------------------------------------

	command_decode command_decode_i (
		.clkin_parallel (clkin_parallel),
		.cpu_resetn     (cpu_resetn),
		.cmd_valid      (cmd_valid),
		.cmd            (cmd),
		.cmd_credit     (cmd_credit),
		.exec_valid     (exec_valid),
		.exec_cmd       (exec_cmd),
		.exec_ready     (exec_ready)
	);

	readout_execute readout_execute_i (
		.clkin_parallel (clkin_parallel),
		.cpu_resetn     (cpu_resetn),
		.hit_valid      (hit_valid),		// ASIC hit words
		.hit_data       (hit_data),
		.exec_valid     (exec_valid),
		.exec_cmd       (exec_cmd),
		.exec_ready     (exec_ready),
		.word_valid     (word_valid),
		.word           (word),
		.word_ready     (word_ready)
	);

	// -----------------------------------------------------------------------
	// Result path
	// -----------------------------------------------------------------------

	result_sender result_sender_i (
		.clkin_parallel (clkin_parallel),
		.cpu_resetn     (cpu_resetn),
		.word_valid     (word_valid),
		.word           (word),
		.word_ready     (word_ready),
		.res_valid      (res_valid),		// Gated by result credits
		.res            (res),
		.res_credit     (res_credit)
	);

endmodule

`default_nettype wire

// ==== result_sender.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module result_sender (
	input  logic                 clkin_parallel,
	input  logic                 cpu_resetn,
	input  logic                 word_valid,
	input  tofpet_pkg::result_t  word,
	output logic                 word_ready,
	output logic                 res_valid,
	output tofpet_pkg::result_t  res,
	input  logic                 res_credit
);

	import tofpet_pkg::*;

	localparam int CR_W = $clog2(`TOFPET_RES_DEPTH + 1);	// Credit counter width

	logic [CR_W-1:0] credits;		// Free slots in host buffer
	logic            buf_empty;
	logic            buf_full;
	logic            have_credit;
	logic            send;			// Word leaves this cycle

	// -----------------------------------------------------------------------
	// Result buffer
	// -----------------------------------------------------------------------

	channel_fifo #(
		.payload_t (result_t),
		.DEPTH     (`TOFPET_RES_DEPTH)
	) res_fifo_i (
		.clkin_parallel (clkin_parallel),
		.cpu_resetn     (cpu_resetn),
		.push           (word_valid),	// Only while word_ready
		.push_data      (word),
		.pop            (send),
		.pop_data       (res),			// Head word on host bus
		.empty          (buf_empty),
		.full           (buf_full),
		.count          ()
	);

	assign word_ready  = !buf_full;		// Falls when host stops returning credits
	assign have_credit = (credits != '0);
	assign send        = !buf_empty && have_credit;
	assign res_valid   = send;			// Cycle after the word is accepted

	// -----------------------------------------------------------------------
	// Result credits
	// -----------------------------------------------------------------------

	always_ff @(posedge clkin_parallel)
	begin
		if (!cpu_resetn)
			credits <= CR_W'(`TOFPET_RES_DEPTH);	// Host buffer empty
		else
		begin
			case ({send, res_credit})
				2'b10:   credits <= credits - 1'b1;	// Word out
				2'b01:   credits <= credits + 1'b1;	// Host retired a word
				default: credits <= credits;		// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== readout_execute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module readout_execute (
	input  logic                         clkin_parallel,
	input  logic                         cpu_resetn,
	input  logic [`TOFPET_CHANNELS-1:0]  hit_valid,
	input  tofpet_pkg::hit_t             hit_data [`TOFPET_CHANNELS],
	input  logic                         exec_valid,
	input  tofpet_pkg::cmd_t             exec_cmd,
	output logic                         exec_ready,
	output logic                         word_valid,
	output tofpet_pkg::result_t          word,
	input  logic                         word_ready
);

	import tofpet_pkg::*;

	localparam int CH    = `TOFPET_CHANNELS;
	localparam int CNT_W = $clog2(`TOFPET_HIT_DEPTH + 1);	// Hit buffer occupancy

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_SINGLE} state_e;

	state_e           state;			// FSM state
	logic [2:0]       cur_chan;			// Channel of current command
	logic [3:0]       remaining;		// Words still to send on READ
	kind_e            reply_kind;		// Kind of current response
	logic [CH-1:0]    overflow;			// Sticky lost-hit flags
	logic [CH-1:0]    hit_empty;
	logic [CH-1:0]    hit_full;
	logic [CH-1:0]    hit_pop;
	hit_t             hit_head [CH];		// Oldest hit per channel
	logic [CNT_W-1:0] hit_count [CH];	// Occupancy per channel
	chan_flags_t      flags;			// STATUS payload
	logic [3:0]       read_len;			// min(count, occupancy)
	logic             accept;			// Command taken
	logic             send;				// Word taken by sender
	logic             clear_ovf;		// STATUS word leaves

	// -----------------------------------------------------------------------
	// Hit buffers, no flow control on the ASIC side
	// -----------------------------------------------------------------------

	for (genvar i = 0; i < CH; i++)
	begin : g_chan
		channel_fifo #(
			.payload_t (hit_t),
			.DEPTH     (`TOFPET_HIT_DEPTH)
		) hit_fifo_i (
			.clkin_parallel (clkin_parallel),
			.cpu_resetn     (cpu_resetn),
			.push           (hit_valid[i]),	// Dropped by buffer when full
			.push_data      (hit_data[i]),
			.pop            (hit_pop[i]),
			.pop_data       (hit_head[i]),
			.empty          (hit_empty[i]),
			.full           (hit_full[i]),
			.count          (hit_count[i])
		);
	end

	always_comb
	begin
		flags.empty    = hit_empty;
		flags.full     = hit_full;
		flags.overflow = overflow;
	end

	assign exec_ready = (state == ST_IDLE);
	assign word_valid = (state != ST_IDLE);
	assign accept     = exec_valid && exec_ready;
	assign send       = word_valid && word_ready;
	assign clear_ovf  = send && state == ST_SINGLE && reply_kind == KIND_STATUS;
	assign read_len   = (exec_cmd.count < hit_count[exec_cmd.channel]) ? exec_cmd.count
		: 4'(hit_count[exec_cmd.channel]);	// Occupancy at start of READ

	// -----------------------------------------------------------------------
	// Result word and hit pop
	// -----------------------------------------------------------------------

	always_comb
	begin
		word         = '0;
		word.kind    = reply_kind;
		word.channel = cur_chan;
		hit_pop      = '0;
		case (state)
			ST_READ:
			begin
				word.last         = (remaining == 4'd1);	// Final hit of READ
				word.data         = hit_head[cur_chan].data;
				hit_pop[cur_chan] = word_ready;			// One hit per word sent
			end
			ST_SINGLE:
			begin
				word.last = 1'b1;
				if (reply_kind == KIND_STATUS)
					word.data[$bits(chan_flags_t)-1:0] = flags;	// Zero-extended
				else if (reply_kind == KIND_ERROR)
					word.data = `TOFPET_ERR_WORD;
			end
			default:
				word.last = 1'b0;
		endcase
	end

	// -----------------------------------------------------------------------
	// FSM and overflow flags
	// -----------------------------------------------------------------------

	always_ff @(posedge clkin_parallel)
	begin
		if (!cpu_resetn)
		begin
			state      <= ST_IDLE;
			cur_chan   <= '0;
			remaining  <= '0;
			reply_kind <= KIND_DATA;
			overflow   <= '0;
		end
		else
		begin
			// New loss wins over the clear
			overflow <= (overflow & ~{CH{clear_ovf}}) | (hit_valid & hit_full);
			case (state)
				ST_IDLE:
					if (accept)
					begin
						cur_chan <= exec_cmd.channel;
						case (exec_cmd.opcode)
							OP_READ:
							begin
								reply_kind <= KIND_DATA;
								remaining  <= read_len;
								state      <= (read_len == 4'd0) ? ST_SINGLE : ST_READ;
							end
							OP_STATUS:
							begin
								reply_kind <= KIND_STATUS;
								state      <= ST_SINGLE;
							end
							default:
							begin
								reply_kind <= KIND_ERROR;	// Undefined opcode
								state      <= ST_SINGLE;
							end
						endcase
					end
				ST_READ:
					if (send)
					begin
						remaining <= remaining - 1'b1;
						if (remaining == 4'd1)
							state <= ST_IDLE;	// Last word gone
					end
				ST_SINGLE:
					if (send)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== command_decode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tofpet_config.svh"

module command_decode (
	input  logic              clkin_parallel,
	input  logic              cpu_resetn,
	input  logic              cmd_valid,
	input  tofpet_pkg::cmd_t  cmd,
	output logic              cmd_credit,
	output logic              exec_valid,
	output tofpet_pkg::cmd_t  exec_cmd,
	input  logic              exec_ready
);

	import tofpet_pkg::*;

	cmd_t checked_cmd;	// Command after channel check
	logic cmd_empty;	// No command waiting
	logic take;		// Executor takes head command

	// -----------------------------------------------------------------------
	// Classification
	// -----------------------------------------------------------------------

	// READ to a missing channel turns into an undefined opcode
	always_comb
	begin
		checked_cmd = cmd;
		if (cmd.opcode == OP_READ && cmd.channel >= `TOFPET_CHANNELS)
			checked_cmd.opcode = opcode_e'(2'd3);	// Executor answers with error
	end

	// -----------------------------------------------------------------------
	// Command buffer
	// -----------------------------------------------------------------------

	channel_fifo #(
		.payload_t (cmd_t),
		.DEPTH     (`TOFPET_CMD_DEPTH)
	) cmd_fifo_i (
		.clkin_parallel (clkin_parallel),
		.cpu_resetn     (cpu_resetn),
		.push           (cmd_valid),		// Host holds a credit
		.push_data      (checked_cmd),
		.pop            (take),
		.pop_data       (exec_cmd),		// Head goes straight out
		.empty          (cmd_empty),
		.full           (),				// Credits keep it from overrunning
		.count          ()
	);

	assign exec_valid = !cmd_empty;		// Earliest one cycle after cmd_valid
	assign take       = exec_valid && exec_ready;
	assign cmd_credit = take;			// Slot freed, credit back to host

endmodule

`default_nettype wire

// ==== channel_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module channel_fifo #(
	parameter type payload_t = logic [7:0],	// Stored word type
	parameter int  DEPTH     = 4			// Number of entries
) (
	input  logic                          clkin_parallel,
	input  logic                          cpu_resetn,
	input  logic                          push,
	input  payload_t                      push_data,
	input  logic                          pop,
	output payload_t                      pop_data,
	output logic                          empty,
	output logic                          full,
	output logic [$clog2(DEPTH+1)-1:0]    count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// Pointer width
	localparam int CNT_W = $clog2(DEPTH + 1);			// Occupancy width

	payload_t         mem [DEPTH];	// Storage, no reset
	logic [PTR_W-1:0] wr_ptr;		// Next slot to write
	logic [PTR_W-1:0] rd_ptr;		// Oldest entry
	logic             do_push;		// Accepted write
	logic             do_pop;		// Accepted read

	// Wrap at DEPTH, works for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push  = push && !full;		// Drop when full
	assign do_pop   = pop && !empty;		// Ignore when empty
	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));
	assign pop_data = mem[rd_ptr];		// Show-ahead head word

	// -----------------------------------------------------------------------
	// Storage
	// -----------------------------------------------------------------------

	always_ff @(posedge clkin_parallel)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;	// Write at tail
	end

	// -----------------------------------------------------------------------
	// Pointers and occupancy
	// -----------------------------------------------------------------------

	always_ff @(posedge clkin_parallel)
	begin
		if (!cpu_resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;		// Starts empty
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;	// Write only
				2'b01:   count <= count - 1'b1;	// Read only
				default: count <= count;		// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tofpet_pkg.sv ====
`default_nettype none
`include "tofpet_config.svh"

package tofpet_pkg;

	// -----------------------------------------------------------------------
	// Host command
	// -----------------------------------------------------------------------

	typedef enum logic [1:0] {
		OP_READ   = 2'd0,	// Drain words from one channel
		OP_STATUS = 2'd1	// Empty, full, overflow of all channels
	} opcode_e;		// Codes 2 and 3 are undefined

	typedef struct packed {
		opcode_e    opcode;	// What to do
		logic [2:0] channel;	// Target channel for READ
		logic [3:0] count;	// Max words for READ
	} cmd_t;

	// -----------------------------------------------------------------------
	// Hit and result words
	// -----------------------------------------------------------------------

	typedef struct packed {
		logic [`TOFPET_WORD_W-1:0] data;	// Raw ASIC hit word
	} hit_t;

	typedef enum logic [1:0] {
		KIND_DATA   = 2'd0,	// Hit data or zero word
		KIND_STATUS = 2'd1,	// Channel flags
		KIND_ERROR  = 2'd2	// Bad opcode or channel
	} kind_e;

	typedef struct packed {
		logic                      last;	// Final word of a response
		kind_e                     kind;	// Word type
		logic [2:0]                channel;	// Source channel
		logic [`TOFPET_WORD_W-1:0] data;	// Payload
	} result_t;

	typedef struct packed {
		logic [`TOFPET_CHANNELS-1:0] empty;	// Buffer empty per channel
		logic [`TOFPET_CHANNELS-1:0] full;	// Buffer full per channel
		logic [`TOFPET_CHANNELS-1:0] overflow;	// Sticky, hit lost
	} chan_flags_t;

endpackage

`default_nettype wire

// ==== tofpet_config.svh ====
`ifndef TOFPET_CONFIG_SVH
`define TOFPET_CONFIG_SVH

// ---------------------------------------------------------------------------
// Readout core sizing
// ---------------------------------------------------------------------------

`define TOFPET_CHANNELS  6             // ASIC channels on the board
`define TOFPET_WORD_W    32            // Hit and result data width

// ---------------------------------------------------------------------------
// Buffer depths and credits
// ---------------------------------------------------------------------------

`define TOFPET_HIT_DEPTH 8             // Entries per hit buffer
`define TOFPET_CMD_DEPTH 4             // Command buffer, also host command credits
`define TOFPET_RES_DEPTH 4             // Host result buffer, initial result credits

`define TOFPET_ERR_WORD  32'hbad0c0de  // Data field of an error reply

`endif
